// ==== rtl/uart_cfg_pkg.sv ====
`default_nettype none

package uart_cfg_pkg;

  // Bit time is kept short so a simulation run stays quick.
  localparam int clks_per_bit    = 8;
  localparam int data_bits       = 8;
  localparam int frame_bits      = 11;  // Start, eight data, parity, stop.
  localparam int gap_bits        = 4;   // Idle bits between header and data of a write.
  localparam int rx_timeout_bits = 32;

  localparam int gap_clks        = gap_bits * clks_per_bit;
  localparam int rx_timeout_clks = rx_timeout_bits * clks_per_bit;

  localparam int baud_cnt_w    = $clog2(clks_per_bit);
  localparam int bit_cnt_w     = $clog2(frame_bits);
  localparam int gap_cnt_w     = $clog2(gap_clks);
  localparam int timeout_cnt_w = $clog2(rx_timeout_clks);

  // Receive sampler states.
  localparam int rx_state_w = 3;
  localparam logic [rx_state_w-1:0] rxs_idle   = 3'd0;
  localparam logic [rx_state_w-1:0] rxs_wait   = 3'd1;  // Armed, looking for a low line.
  localparam logic [rx_state_w-1:0] rxs_start  = 3'd2;
  localparam logic [rx_state_w-1:0] rxs_data   = 3'd3;
  localparam logic [rx_state_w-1:0] rxs_parity = 3'd4;
  localparam logic [rx_state_w-1:0] rxs_stop   = 3'd5;

endpackage

`default_nettype wire

// ==== rtl/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  localparam int addr_bits = 7;

  typedef logic [uart_cfg_pkg::data_bits-1:0] uart_byte_t;

  typedef struct packed {
    logic                 rw;     // 1 is write.
    logic [addr_bits-1:0] addr;
    uart_byte_t           wdata;
  } cmd_fields_t;

  // Same word as it goes out on the line.
  typedef struct packed {
    uart_byte_t hdr;
    uart_byte_t data;
  } cmd_bytes_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_t;

  typedef struct packed {
    logic parity_err;
    logic timeout;
  } read_status_t;

  // Command sequencer states.
  localparam int seq_state_w = 3;
  localparam logic [seq_state_w-1:0] seq_init      = 3'd0;
  localparam logic [seq_state_w-1:0] seq_idle      = 3'd1;
  localparam logic [seq_state_w-1:0] seq_header    = 3'd2;
  localparam logic [seq_state_w-1:0] seq_gap       = 3'd3;
  localparam logic [seq_state_w-1:0] seq_data      = 3'd4;
  localparam logic [seq_state_w-1:0] seq_wait_resp = 3'd5;

endpackage

`default_nettype wire

// ==== rtl/uart_cmd_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_word_t  cmd_word,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output uart_cmd_pkg::uart_byte_t tx_byte,
  input  logic                     tx_done,
  output logic                     rx_arm,
  input  logic                     rx_done,
  input  logic                     result_busy
);

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  logic [seq_state_w-1:0] state;
  logic [gap_cnt_w-1:0]   gap_cnt;
  cmd_word_t              cmd_q;
  logic                   accept;
  logic                   gap_end;

  assign cmd_rdy = (state == seq_idle) && !result_busy;
  assign accept  = cmd_vld && cmd_rdy;

  // Fires one cycle early so the data start bit lands exactly on the gap end.
  assign gap_end = (state == seq_gap) && (gap_cnt == gap_cnt_w'(gap_clks - 2));

  // Header leaves straight from the input word.
  assign tx_start = accept || gap_end;
  assign tx_byte  = (state == seq_idle) ? cmd_word.bytes.hdr : cmd_q.bytes.data;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= seq_init;
      gap_cnt <= '0;
      rx_arm  <= 1'b0;
    end
    else
    begin
      rx_arm <= 1'b0;
      case (state)
        seq_init:
        begin
          state <= seq_idle;
        end
        seq_idle:
        begin
          if (accept)
          begin
            state <= seq_header;
          end
        end
        seq_header:
        begin
          if (tx_done)
          begin
            if (cmd_q.fields.rw)
            begin
              state   <= seq_gap;
              gap_cnt <= '0;
            end
            else
            begin
              state  <= seq_wait_resp;
              rx_arm <= 1'b1;   // Sampler listens right after the header.
            end
          end
        end
        seq_gap:
        begin
          gap_cnt <= gap_cnt + gap_cnt_w'(1);
          if (gap_end)
          begin
            state <= seq_data;
          end
        end
        seq_data:
        begin
          if (tx_done)
          begin
            state <= seq_idle;
          end
        end
        seq_wait_resp:
        begin
          if (rx_done)
          begin
            state <= seq_idle;
          end
        end
        default:
        begin
          state <= seq_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx_frame.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx_frame (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tx_start,
  input  uart_cmd_pkg::uart_byte_t tx_byte,
  output logic                     tx_done,
  output logic                     tx
);

  import uart_cfg_pkg::*;

  logic [frame_bits-1:0] shreg;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic                  busy;
  logic                  bit_end;
  logic                  load;

  assign load    = tx_start && !busy;
  assign bit_end = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));
  assign tx_done = busy && bit_end && (bit_cnt == bit_cnt_w'(frame_bits - 1));
  assign tx      = busy ? shreg[0] : 1'b1;   // Line idles high.

  // Frame is shifted out LSB first, start bit in bit 0.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shreg <= {1'b1, ^tx_byte, tx_byte, 1'b0};
    end
    else if (busy && bit_end)
    begin
      shreg <= {1'b1, shreg[frame_bits-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (load)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + bit_cnt_w'(1);
        if (tx_done)
        begin
          busy <= 1'b0;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + baud_cnt_w'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_rx_frame.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rx,
  input  logic                       rx_arm,
  output logic                       rx_done,
  output uart_cmd_pkg::uart_byte_t   rx_byte,
  output uart_cmd_pkg::read_status_t rx_status
);

  import uart_cfg_pkg::*;

  logic                     rx_s1;
  logic                     rx_s2;
  logic [rx_state_w-1:0]    state;
  logic [baud_cnt_w-1:0]    baud_cnt;
  logic [bit_cnt_w-1:0]     bit_cnt;
  logic [timeout_cnt_w-1:0] timeout_cnt;
  logic                     half_bit;
  logic                     full_bit;
  logic                     timeout_hit;

  assign half_bit    = (baud_cnt == baud_cnt_w'(clks_per_bit / 2 - 1));
  assign full_bit    = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));
  assign timeout_hit = rx_s2 && (timeout_cnt == timeout_cnt_w'(rx_timeout_clks - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
    end
  end

  // Byte fills from the top so the first bit ends in bit 0.
  always_ff @(posedge clk)
  begin
    if (state == rxs_idle && rx_arm)
    begin
      rx_byte   <= '0;
      rx_status <= '0;
    end
    else if (state == rxs_wait && timeout_hit)
    begin
      rx_status.timeout <= 1'b1;
    end
    else if (state == rxs_data && full_bit)
    begin
      rx_byte <= {rx_s2, rx_byte[data_bits-1:1]};
    end
    else if (state == rxs_parity && full_bit)
    begin
      rx_status.parity_err <= rx_s2 ^ (^rx_byte);   // Even parity.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= rxs_idle;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
      timeout_cnt <= '0;
      rx_done     <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      case (state)
        rxs_idle:
        begin
          if (rx_arm)
          begin
            state       <= rxs_wait;
            timeout_cnt <= '0;
          end
        end
        rxs_wait:
        begin
          if (!rx_s2)
          begin
            state    <= rxs_start;
            baud_cnt <= '0;
          end
          else if (timeout_hit)
          begin
            state   <= rxs_idle;
            rx_done <= 1'b1;
          end
          else
          begin
            timeout_cnt <= timeout_cnt + timeout_cnt_w'(1);
          end
        end
        rxs_start:
        begin
          if (half_bit)
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s2 ? rxs_wait : rxs_data;   // High at mid-bit is a glitch.
          end
          else
          begin
            baud_cnt <= baud_cnt + baud_cnt_w'(1);
          end
        end
        rxs_data, rxs_parity, rxs_stop:
        begin
          if (full_bit)
          begin
            baud_cnt <= '0;
            if (state == rxs_data)
            begin
              bit_cnt <= bit_cnt + bit_cnt_w'(1);
              if (bit_cnt == bit_cnt_w'(data_bits - 1))
              begin
                state <= rxs_parity;
              end
            end
            else if (state == rxs_parity)
            begin
              state <= rxs_stop;
            end
            else
            begin
              // Stop bit value is not checked.
              state   <= rxs_idle;
              rx_done <= 1'b1;
            end
          end
          else
          begin
            baud_cnt <= baud_cnt + baud_cnt_w'(1);
          end
        end
        default:
        begin
          state <= rxs_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_read_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_read_result (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rx_done,
  input  uart_cmd_pkg::uart_byte_t   rx_byte,
  input  uart_cmd_pkg::read_status_t rx_status,
  output logic                       read_vld,
  input  logic                       read_rdy,
  output uart_cmd_pkg::uart_byte_t   read_data,
  output uart_cmd_pkg::read_status_t read_status,
  output logic                       result_busy
);

  // Only one read is ever outstanding, so a new answer never meets a held one.
  always_ff @(posedge clk)
  begin
    if (rx_done)
    begin
      read_data   <= rx_byte;
      read_status <= rx_status;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld <= 1'b0;
    end
    else if (rx_done)
    begin
      read_vld <= 1'b1;
    end
    else if (read_rdy)
    begin
      read_vld <= 1'b0;   // Handshake taken.
    end
  end

  assign result_busy = read_vld;

endmodule

`default_nettype wire

// ==== rtl/uart_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_word_t    cmd_word,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  input  logic                       rx,
  output logic                       tx,
  output logic                       read_vld,
  input  logic                       read_rdy,
  output uart_cmd_pkg::uart_byte_t   read_data,
  output uart_cmd_pkg::read_status_t read_status
);

  import uart_cmd_pkg::*;

  logic         tx_start;
  uart_byte_t   tx_byte;
  logic         tx_done;
  logic         rx_arm;
  logic         rx_done;
  uart_byte_t   rx_byte;
  read_status_t rx_status;
  logic         result_busy;

  uart_cmd_decode i_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_word    (cmd_word),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte),
    .tx_done     (tx_done),
    .rx_arm      (rx_arm),
    .rx_done     (rx_done),
    .result_busy (result_busy)
  );

  uart_tx_frame i_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx_frame i_rx_frame (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_status (rx_status)
  );

  // Holds the answer until the host takes it; this stalls new commands.
  uart_read_result i_read_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_done     (rx_done),
    .rx_byte     (rx_byte),
    .rx_status   (rx_status),
    .read_vld    (read_vld),
    .read_rdy    (read_rdy),
    .read_data   (read_data),
    .read_status (read_status),
    .result_busy (result_busy)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 5;   // 10 ns clock.
  localparam int reset_cycles = 8;

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/tb_uart_cmd_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uart_cmd_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       cmd_rdy,
  input logic                       tx,
  input logic                       read_vld,
  input logic                       read_rdy,
  input uart_cmd_pkg::uart_byte_t   read_data,
  input uart_cmd_pkg::read_status_t read_status
);

  logic seq_idle;

  // Sequencer sits in idle exactly when it is ready or a read answer is held.
  assign seq_idle = cmd_rdy || read_vld;

  result_stable: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld && !read_rdy |=> $stable(read_data) && $stable(read_status))
    else $error("read result changed while waiting for read_rdy");

  no_cmd_while_held: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> !cmd_rdy)
    else $error("cmd_rdy high while a read result is held");

  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    seq_idle |-> tx)
    else $error("tx low while the sequencer is idle");

endmodule

bind uart_cmd_top tb_uart_cmd_assert i_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .cmd_rdy     (cmd_rdy),
  .tx          (tx),
  .read_vld    (read_vld),
  .read_rdy    (read_rdy),
  .read_data   (read_data),
  .read_status (read_status)
);

`default_nettype wire

// ==== test/tb_uart_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uart_cmd;

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  localparam int num_fixed  = 10;
  localparam int num_rows   = 22;
  localparam int max_hold   = 7;
  localparam int max_delay  = 73;
  localparam int frame_clks = frame_bits * clks_per_bit;
  // tx_done sits in the last frame cycle, the next start comes gap_clks later.
  localparam int write_gap_clks = frame_clks - 1 + gap_clks;
  localparam int row_max_clks   = 2 * frame_clks + gap_clks + rx_timeout_clks
                                  + max_delay + max_hold + 16;
  localparam int cycle_limit    = num_rows * row_max_clks + 100;

  typedef struct {
    cmd_word_t  cmd;
    uart_byte_t resp;
    logic       flip;      // Response parity inverted.
    logic       no_resp;
    int         hold;      // Cycles read_rdy stays low.
    int         delay;     // Idle cycles before the response frame.
  } row_t;

  logic         clk;
  logic         rst_n;
  cmd_word_t    cmd_word;
  logic         cmd_vld;
  logic         cmd_rdy;
  logic         rx;
  logic         tx;
  logic         read_vld;
  logic         read_rdy;
  uart_byte_t   read_data;
  read_status_t read_status;

  row_t         rows [num_rows];
  uart_byte_t   cap_byte [$];
  logic         cap_par [$];
  logic         cap_stop [$];
  int           cap_start [$];
  int           last_start;
  int           cycle_cnt = 0;
  int           err_count = 0;
  int           checks_done = 0;

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_top i_uart_cmd_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_word    (cmd_word),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .rx          (rx),
    .tx          (tx),
    .read_vld    (read_vld),
    .read_rdy    (read_rdy),
    .read_data   (read_data),
    .read_status (read_status)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic set_row(input int idx, input logic [15:0] cmd, input uart_byte_t resp,
                         input logic flip, input logic no_resp, input int hold,
                         input int delay);
    rows[idx].cmd     = cmd;
    rows[idx].resp    = resp;
    rows[idx].flip    = flip;
    rows[idx].no_resp = no_resp;
    rows[idx].hold    = hold;
    rows[idx].delay   = delay;
  endtask

  task automatic fill_table();
    logic [31:0] rng;
    logic [31:0] r2;
    set_row(0, 16'h92A5, 8'h00, 1'b0, 1'b0, 0, 10);   // Write 0x12.
    set_row(1, 16'hFF00, 8'h00, 1'b0, 1'b0, 0, 10);
    set_row(2, 16'h0500, 8'h3C, 1'b0, 1'b0, 0, 10);   // Plain reads.
    set_row(3, 16'h4000, 8'hFF, 1'b0, 1'b0, 1, 25);
    set_row(4, 16'h2100, 8'h81, 1'b1, 1'b0, 2, 12);   // Bad parity.
    set_row(5, 16'h0A00, 8'h00, 1'b0, 1'b1, 0, 10);   // Silent remote.
    set_row(6, 16'h3300, 8'h5A, 1'b0, 1'b0, 5, 40);
    set_row(7, 16'h8001, 8'h00, 1'b0, 1'b0, 0, 10);
    set_row(8, 16'h7F00, 8'h00, 1'b1, 1'b0, 3, 73);
    set_row(9, 16'h1200, 8'h00, 1'b0, 1'b1, 4, 10);
    rng = 32'd44584;
    for (int i = num_fixed; i < num_rows; i++)
    begin
      rng = xorshift32(rng);
      r2  = xorshift32(rng);
      rng = r2;
      rows[i].cmd     = r2[15:0];
      rows[i].resp    = r2[23:16];
      rows[i].flip    = r2[24];
      rows[i].no_resp = (r2[27:25] == 3'd0);
      rows[i].hold    = int'(r2[30:28]);
      rows[i].delay   = 10 + int'(r2[5:0]) % 64;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp)
    begin
      $display("ERROR @ %0t: %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks_done++;
    if (got != exp)
    begin
      $display("ERROR @ %0t: %s got %0d expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Takes the next frame rebuilt by the line model.
  task automatic check_byte(input uart_byte_t exp);
    uart_byte_t got;
    logic       par;
    logic       stop;
    while (cap_byte.size() == 0) @(negedge clk);
    got        = cap_byte.pop_front();
    par        = cap_par.pop_front();
    stop       = cap_stop.pop_front();
    last_start = cap_start.pop_front();
    check_level("tx_parity", par, ^exp);   // Even parity.
    check_level("tx_stop", stop, 1'b1);
    checks_done++;
    if (got !== exp)
    begin
      $display("ERROR @ %0t: tx_data got %h expected %h", $time, got, exp);
      err_count++;
    end
  endtask

  task automatic check_read(input uart_byte_t exp_data, input read_status_t exp_status);
    checks_done++;
    if (read_data !== exp_data)
    begin
      $display("ERROR @ %0t: read_data got %h expected %h", $time, read_data, exp_data);
      err_count++;
    end
    if (read_status !== exp_status)
    begin
      $display("ERROR @ %0t: read_status got %b expected %b", $time, read_status,
               exp_status);
      err_count++;
    end
  endtask

  task automatic issue_command(input cmd_word_t cmd);
    @(posedge clk);
    cmd_word <= cmd;
    cmd_vld  <= 1'b1;
    do @(negedge clk); while (!cmd_rdy);
    @(posedge clk);   // Accepting edge.
    cmd_vld <= 1'b0;
  endtask

  // Remote device answer, one bit every clks_per_bit cycles.
  task automatic send_response(input uart_byte_t data, input logic flip, input int delay);
    logic [frame_bits-1:0] frame;
    frame = {1'b1, (^data) ^ flip, data, 1'b0};
    repeat (delay) @(posedge clk);
    for (int i = 0; i < frame_bits; i++)
    begin
      rx <= frame[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  task automatic take_result(input uart_byte_t exp_data, input read_status_t exp_status,
                             input int hold);
    do @(negedge clk); while (!read_vld);
    check_read(exp_data, exp_status);
    check_level("cmd_rdy", cmd_rdy, 1'b0);
    repeat (hold)
    begin
      @(negedge clk);
      check_read(exp_data, exp_status);   // Held steady.
      check_level("cmd_rdy", cmd_rdy, 1'b0);
    end
    @(posedge clk);
    read_rdy <= 1'b1;
    @(posedge clk);
    read_rdy <= 1'b0;
    @(negedge clk);
    check_level("read_vld", read_vld, 1'b0);
  endtask

  task automatic run_row(input int idx);
    row_t         row;
    uart_byte_t   exp_data;
    read_status_t exp_status;
    int           first_start;
    int           errs_before;
    row         = rows[idx];
    errs_before = err_count;
    issue_command(row.cmd);
    check_byte({row.cmd.fields.rw, row.cmd.fields.addr});
    first_start = last_start;
    if (row.cmd.fields.rw)
    begin
      check_byte(row.cmd.fields.wdata);
      check_count("frame_gap", last_start - first_start, write_gap_clks);
    end
    else
    begin
      if (row.no_resp)
      begin
        exp_data              = 8'h00;
        exp_status.parity_err = 1'b0;
        exp_status.timeout    = 1'b1;
      end
      else
      begin
        send_response(row.resp, row.flip, row.delay);
        exp_data              = row.resp;
        exp_status.parity_err = row.flip;
        exp_status.timeout    = 1'b0;
      end
      take_result(exp_data, exp_status, row.hold);
    end
    while (!cmd_rdy) @(negedge clk);
    check_count("extra_frames", cap_byte.size(), 0);
    $display("row %0d %s cmd %h: %s", idx, row.cmd.fields.rw ? "write" : "read",
             row.cmd, (err_count == errs_before) ? "ok" : "failed");
  endtask

  // Line model rebuilds every frame seen on tx.
  always
  begin : line_model
    logic [frame_bits-1:0] bits;
    int                    start_cyc;
    @(negedge clk);
    if (rst_n && !tx)
    begin
      start_cyc = cycle_cnt;
      repeat (clks_per_bit / 2 - 1) @(negedge clk);
      bits[0] = tx;
      for (int i = 1; i < frame_bits; i++)
      begin
        repeat (clks_per_bit) @(negedge clk);
        bits[i] = tx;
      end
      if (bits[0] !== 1'b0)
      begin
        $display("A frame on tx lost its start bit before the middle of the bit.");
        err_count++;
      end
      cap_byte.push_back(bits[data_bits:1]);
      cap_par.push_back(bits[data_bits+1]);
      cap_stop.push_back(bits[data_bits+2]);
      cap_start.push_back(start_cyc);
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("The run hit its limit of %0d cycles before all rows were done.",
               cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial
  begin
    cmd_word = '0;
    cmd_vld  = 1'b0;
    read_rdy = 1'b0;
    rx       = 1'b1;   // Remote line idles high.
    fill_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_level("tx", tx, 1'b1);
    check_level("read_vld", read_vld, 1'b0);
    @(negedge clk);
    check_level("cmd_rdy", cmd_rdy, 1'b1);
    $display("reset values: %s", (err_count == 0) ? "ok" : "failed");
    for (int r = 0; r < num_rows; r++)
    begin
      run_row(r);
    end
    $display("Done: %0d rows, %0d checks, %0d errors.", num_rows, checks_done, err_count);
    if (err_count == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/uart_cfg_pkg.sv
rtl/uart_cmd_pkg.sv
rtl/uart_cmd_decode.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_read_result.sv
rtl/uart_cmd_top.sv
test/tb_clock_gen.sv
test/tb_uart_cmd_assert.sv
test/tb_uart_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART command bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_uart_cmd -f build.f -o sim_uart_cmd

./obj_dir/sim_uart_cmd | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log
then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi
